// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 16;

	// Instruction bits 15..12
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		SHR = 4'h6,
		MOV = 4'h7,
		LDI = 4'h8,
		LD  = 4'h9,
		ST  = 4'ha,
		JMP = 4'hb,
		JZ  = 4'hc,
		JC  = 4'hd,
		JR  = 4'he,
		NOP = 4'hf
	} opcodeT;

	// Next-PC source
	typedef enum logic [1:0] {
		PC_INC = 2'd0,
		PC_IMM = 2'd1,
		PC_REG = 2'd2
	} pcSelT;

	typedef struct packed {
		opcodeT op;
		logic [3:0] regDst;
		logic [3:0] regSrc;
		logic regWe;
		logic memWe;
		pcSelT pcSel;
		// Write-back takes imm8
		logic immMode;
		// Write-back takes data memory
		logic memRead;
		logic flagWe;
		logic [dataWidth-1:0] imm;
	} ctrlT;

	// Instruction retiring at the coming edge
	typedef struct packed {
		logic [dataWidth-1:0] pc;
		logic [dataWidth-1:0] instr;
		logic regWe;
		logic [3:0] regDst;
		logic [dataWidth-1:0] regWrData;
		logic memWe;
		logic [dataWidth-1:0] memAddr;
		logic [dataWidth-1:0] memWrData;
	} traceT;

	// The seven opcodes that go through the ALU and set flags
	function automatic logic isAluOp(opcodeT op);
		case (op)
			ADD, SUB, AND, OR, XOR, SHL, SHR: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic isJump(opcodeT op);
		case (op)
			JMP, JZ, JC, JR: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile
	import cpuPkg::*;
#(
	parameter int regCount = 16
) (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [3:0] regDst,
	input logic [3:0] regSrc,
	input logic [dataWidth-1:0] regDstDataIn,
	output logic [dataWidth-1:0] regDstDataOut,
	output logic [dataWidth-1:0] regSrcDataOut
);

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[regDst] <= regDstDataIn;
		end
	end

	// Both read ports are combinational
	assign regDstDataOut = regs[regDst];
	assign regSrcDataOut = regs[regSrc];

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input opcodeT op,
	input logic flagWe,
	input logic [dataWidth-1:0] in1,
	input logic [dataWidth-1:0] in2,
	output logic [dataWidth-1:0] out,
	output logic cFlag,
	output logic zFlag
);

	logic [dataWidth:0] wide;
	logic carry;

	always_comb begin
		wide = '0;
		carry = 1'b0;
		out = '0;
		case (op)
			ADD: begin
				wide = {1'b0, in1} + {1'b0, in2};
				out = wide[dataWidth-1:0];
				carry = wide[dataWidth];
			end
			SUB: begin
				// Top bit is the unsigned borrow
				wide = {1'b0, in1} - {1'b0, in2};
				out = wide[dataWidth-1:0];
				carry = wide[dataWidth];
			end
			AND: begin
				out = in1 & in2;
			end
			OR: begin
				out = in1 | in2;
			end
			XOR: begin
				out = in1 ^ in2;
			end
			SHL: begin
				out = {in1[dataWidth-2:0], 1'b0};
				carry = in1[dataWidth-1];
			end
			SHR: begin
				out = {1'b0, in1[dataWidth-1:1]};
				carry = in1[0];
			end
			MOV: begin
				out = in2;
			end
			default: begin
				out = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagWe) begin
			cFlag <= carry;
			zFlag <= (out == '0);
		end
	end

endmodule

`default_nettype wire

// File: source/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder
	import cpuPkg::*;
(
	input logic [dataWidth-1:0] instruction,
	input logic cFlag,
	input logic zFlag,
	output ctrlT ctrl
);

	opcodeT op;

	assign op = opcodeT'(instruction[15:12]);

	always_comb begin
		ctrl.op = op;
		ctrl.regDst = instruction[11:8];
		ctrl.regSrc = instruction[7:4];
		ctrl.imm = {{(dataWidth-8){1'b0}}, instruction[7:0]};
		ctrl.regWe = 1'b0;
		ctrl.memWe = 1'b0;
		ctrl.immMode = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.flagWe = isAluOp(op);
		ctrl.pcSel = PC_INC;

		case (op)
			ADD, SUB, AND, OR, XOR, SHL, SHR: begin
				ctrl.regWe = 1'b1;
			end
			MOV: begin
				ctrl.regWe = 1'b1;
			end
			LDI: begin
				ctrl.regWe = 1'b1;
				ctrl.immMode = 1'b1;
			end
			LD: begin
				ctrl.regWe = 1'b1;
				ctrl.memRead = 1'b1;
			end
			ST: begin
				ctrl.memWe = 1'b1;
			end
			JMP: begin
				ctrl.pcSel = PC_IMM;
			end
			// Conditional jumps see the flags from before this instruction
			JZ: begin
				if (zFlag) begin
					ctrl.pcSel = PC_IMM;
				end
			end
			JC: begin
				if (cFlag) begin
					ctrl.pcSel = PC_IMM;
				end
			end
			JR: begin
				ctrl.pcSel = PC_REG;
			end
			default: begin
				ctrl.pcSel = PC_INC;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/processor.sv
`timescale 1ns/1ns
`default_nettype none

module processor
	import cpuPkg::*;
#(
	parameter int regCount = 16
) (
	input logic clk,
	input logic rst,
	output logic [dataWidth-1:0] instrAddr,
	input logic [dataWidth-1:0] instrData,
	output logic memWe,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWrData,
	input logic [dataWidth-1:0] memRdData,
	output traceT trace
);

	ctrlT ctrl;
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] nextPc;
	logic [dataWidth-1:0] dstData;
	logic [dataWidth-1:0] srcData;
	logic [dataWidth-1:0] aluOut;
	logic [dataWidth-1:0] wbData;
	logic cFlag;
	logic zFlag;

	decoder decode0 (
		.instruction(instrData),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.ctrl(ctrl)
	);

	registerFile #(
		.regCount(regCount)
	) regFile0 (
		.clk(clk),
		.rst(rst),
		.we(ctrl.regWe),
		.regDst(ctrl.regDst),
		.regSrc(ctrl.regSrc),
		.regDstDataIn(wbData),
		.regDstDataOut(dstData),
		.regSrcDataOut(srcData)
	);

	alu alu0 (
		.clk(clk),
		.rst(rst),
		.op(ctrl.op),
		.flagWe(ctrl.flagWe),
		.in1(dstData),
		.in2(srcData),
		.out(aluOut),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	always_comb begin
		case (ctrl.pcSel)
			PC_IMM: nextPc = ctrl.imm;
			PC_REG: nextPc = srcData;
			default: nextPc = pc + dataWidth'(1);
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

	// Write-back priority is imm, then memory, then ALU
	always_comb begin
		if (ctrl.immMode) begin
			wbData = ctrl.imm;
		end else if (ctrl.memRead) begin
			wbData = memRdData;
		end else begin
			wbData = aluOut;
		end
	end

	assign instrAddr = pc;
	// ST addresses through dst, LD through src
	assign memAddr = (ctrl.op == ST) ? dstData : srcData;
	assign memWrData = srcData;
	// No stores while the memory contents are still being loaded
	assign memWe = ctrl.memWe & ~rst;

	always_comb begin
		trace.pc = pc;
		trace.instr = instrData;
		trace.regWe = ctrl.regWe;
		trace.regDst = ctrl.regDst;
		trace.regWrData = wbData;
		trace.memWe = memWe;
		trace.memAddr = memAddr;
		trace.memWrData = memWrData;
	end

endmodule

`default_nettype wire

// File: source/processorTop.sv
`timescale 1ns/1ns
`default_nettype none

module processorTop
	import cpuPkg::*;
#(
	parameter int imemDepth = 128,
	parameter int dmemDepth = 128,
	parameter int regCount = 16
) (
	input logic clk,
	input logic rst,
	input logic progWe,
	input logic [dataWidth-1:0] progAddr,
	input logic [dataWidth-1:0] progData,
	output traceT trace
);

	// Addresses wrap on the low bits
	localparam int imemAddrBits = $clog2(imemDepth);
	localparam int dmemAddrBits = $clog2(dmemDepth);

	logic [dataWidth-1:0] imem [imemDepth];
	logic [dataWidth-1:0] dmem [dmemDepth];

	logic [dataWidth-1:0] instrAddr;
	logic [dataWidth-1:0] instrData;
	logic memWe;
	logic [dataWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWrData;
	logic [dataWidth-1:0] memRdData;

	// Program load port works during reset too
	always_ff @(posedge clk) begin
		if (progWe) begin
			imem[progAddr[imemAddrBits-1:0]] <= progData;
		end
	end

	assign instrData = imem[instrAddr[imemAddrBits-1:0]];

	always_ff @(posedge clk) begin
		if (memWe) begin
			dmem[memAddr[dmemAddrBits-1:0]] <= memWrData;
		end
	end

	assign memRdData = dmem[memAddr[dmemAddrBits-1:0]];

	processor #(
		.regCount(regCount)
	) cpu0 (
		.clk(clk),
		.rst(rst),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memRdData(memRdData),
		.trace(trace)
	);

endmodule

`default_nettype wire

// File: verif/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
	parameter int period = 100,
	parameter int resetCycles = 3
) (
	input logic hold,
	output logic clk,
	output logic rst
);

	int count;
	logic tail;

	initial begin
		clk = 1'b0;
		count = 0;
		tail = 1'b1;
	end

	always #(period / 2) clk = ~clk;

	// Reset stays up for resetCycles edges after hold drops
	always @(posedge clk) begin
		if (hold) begin
			count = 0;
		end else if (count < resetCycles) begin
			count++;
		end
		#10;
		tail = (count < resetCycles);
	end

	assign rst = hold | tail;

endmodule

`default_nettype wire

// File: verif/processor_props.sv
`timescale 1ns/1ns
`default_nettype none

module processorProps
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input ctrlT ctrl,
	input logic memWe,
	input logic [dataWidth-1:0] pc
);

	storeOnly: assert property (@(posedge clk) memWe |-> ctrl.op == ST)
		else $error("memWe high for opcode %h", ctrl.op);

	noRegWriteOnStoreOrJump: assert property (@(posedge clk)
		ctrl.regWe |-> !(ctrl.op inside {ST, JMP, JZ, JC, JR}))
		else $error("regWe high for opcode %h", ctrl.op);

	pcZeroAfterReset: assert property (@(posedge clk) $fell(rst) |-> pc == '0)
		else $error("pc is %h in the first cycle after reset", pc);

	// A reset in the next cycle overrides the increment
	pcIncrements: assert property (@(posedge clk)
		(!rst && ctrl.pcSel == PC_INC) |=> (rst || pc == $past(pc) + 16'd1))
		else $error("pc did not advance by one, now %h", pc);

endmodule

`default_nettype wire

// File: verif/processorTb.sv
`timescale 1ns/1ns
`default_nettype none

module processorTb
	import cpuPkg::*;
();

	localparam int testCount = 5;
	localparam int progWords = 128;
	localparam int runCycles = 200;
	localparam int resetCycles = 3;
	localparam int cycleLimit = testCount * (progWords + resetCycles + runCycles) + 100;

	logic clk;
	logic rst;
	logic hold;
	logic progWe;
	logic [dataWidth-1:0] progAddr;
	logic [dataWidth-1:0] progData;
	traceT trace;

	integer seed;
	int cycles;
	int testErrors;
	int passCount;
	int failCount;

	// Instruction-set model state
	logic [dataWidth-1:0] prog [progWords];
	logic [dataWidth-1:0] dmem [progWords];
	logic [dataWidth-1:0] regs [16];
	logic [dataWidth-1:0] pc;
	logic cFlag;
	logic zFlag;

	tbClock #(
		.period(100),
		.resetCycles(resetCycles)
	) clock0 (
		.hold(hold),
		.clk(clk),
		.rst(rst)
	);

	processorTop #(
		.imemDepth(128),
		.dmemDepth(128),
		.regCount(16)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.trace(trace)
	);

	bind processor processorProps props0 (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.memWe(memWe),
		.pc(pc)
	);

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Timeout: the run went past %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic opcodeT jumpMix(int roll);
		case (roll)
			0, 1, 2, 3, 4: return opcodeT'(4'(roll));
			5, 6, 7: return LDI;
			8: return JMP;
			9, 10: return JZ;
			11, 12: return JC;
			13: return JR;
			default: return NOP;
		endcase
	endfunction

	task automatic makeProgram(input int testNum);
		int roll;
		logic [dataWidth-1:0] word;
		opcodeT op;
		for (int i = 0; i < progWords; i++) begin
			roll = int'($unsigned($random(seed)) % 16);
			word = 16'($random(seed));
			// Conditional jumps make the flags visible in the trace
			case (testNum)
				0: op = (roll < 11) ? opcodeT'(4'(roll % 8)) :
					(roll == 13) ? JZ : (roll == 14) ? JC : LDI;
				1: op = (roll < 8) ? LDI : (roll < 14) ? opcodeT'(4'(roll % 8)) :
					(roll == 14) ? JZ : JC;
				2: op = (roll < 5) ? LDI : (roll < 10) ? ST : (roll < 14) ? LD : ADD;
				3: op = jumpMix(roll);
				default: op = opcodeT'(word[15:12]);
			endcase
			prog[i] = {op, word[11:0]};
		end
	endtask

	// Program goes in while reset is held
	task automatic loadProgram();
		@(posedge clk);
		#10;
		hold = 1'b1;
		for (int i = 0; i < progWords; i++) begin
			progWe = 1'b1;
			progAddr = 16'(i);
			progData = prog[i];
			@(posedge clk);
			#10;
		end
		progWe = 1'b0;
		hold = 1'b0;
	endtask

	task automatic compareField(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] exp);
		if (got !== exp) begin
			testErrors++;
			$display("ERROR: %s is %h, expected %h (model pc %h)", name, got, exp, pc);
		end
	endtask

	task automatic checkAndStep();
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] d;
		logic [dataWidth-1:0] s;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] result;
		logic [dataWidth-1:0] nextPc;
		logic [3:0] dst;
		logic carry;
		logic expRegWe;
		logic expMemWe;
		opcodeT op;
		instr = prog[pc[6:0]];
		op = opcodeT'(instr[15:12]);
		dst = instr[11:8];
		d = regs[dst];
		s = regs[instr[7:4]];
		imm = {8'h00, instr[7:0]};
		result = '0;
		carry = 1'b0;
		expRegWe = 1'b1;
		expMemWe = 1'b0;
		nextPc = pc + 16'd1;
		case (op)
			ADD: begin
				result = d + s;
				carry = result < d;
			end
			SUB: begin
				result = d - s;
				carry = d < s;
			end
			AND: result = d & s;
			OR: result = d | s;
			XOR: result = d ^ s;
			SHL: begin
				result = d << 1;
				carry = d[15];
			end
			SHR: begin
				result = d >> 1;
				carry = d[0];
			end
			MOV: result = s;
			LDI: result = imm;
			LD: result = dmem[s[6:0]];
			ST: begin
				expRegWe = 1'b0;
				expMemWe = 1'b1;
			end
			JMP: begin
				expRegWe = 1'b0;
				nextPc = imm;
			end
			JZ: begin
				expRegWe = 1'b0;
				nextPc = zFlag ? imm : nextPc;
			end
			JC: begin
				expRegWe = 1'b0;
				nextPc = cFlag ? imm : nextPc;
			end
			JR: begin
				expRegWe = 1'b0;
				nextPc = s;
			end
			default: expRegWe = 1'b0;
		endcase

		compareField("pc", trace.pc, pc);
		compareField("instr", trace.instr, instr);
		compareField("regWe", 16'(trace.regWe), 16'(expRegWe));
		compareField("memWe", 16'(trace.memWe), 16'(expMemWe));
		if (expRegWe) begin
			compareField("regDst", 16'(trace.regDst), 16'(dst));
			compareField("regWrData", trace.regWrData, result);
		end
		if (expMemWe) begin
			compareField("memAddr", trace.memAddr, d);
			compareField("memWrData", trace.memWrData, s);
		end

		if (expRegWe) begin
			regs[dst] = result;
		end
		if (expMemWe) begin
			dmem[d[6:0]] = s;
		end
		if (op inside {ADD, SUB, AND, OR, XOR, SHL, SHR}) begin
			cFlag = carry;
			zFlag = (result == '0);
		end
		pc = nextPc;
	endtask

	task automatic runTest(input int testNum, input string name);
		makeProgram(testNum);
		loadProgram();
		for (int r = 0; r < 16; r++) begin
			regs[r] = '0;
		end
		pc = '0;
		cFlag = 1'b0;
		zFlag = 1'b0;
		testErrors = 0;
		do begin
			@(negedge clk);
		end while (rst);
		// Trace is checked mid-cycle, before the edge that retires it
		for (int c = 0; c < runCycles; c++) begin
			if (c > 0) begin
				@(negedge clk);
			end
			checkAndStep();
		end
		if (testErrors == 0) begin
			passCount++;
			$display("Test %0d (%s): passed", testNum, name);
		end else begin
			failCount++;
			$display("Test %0d (%s): failed with %0d mismatches", testNum, name, testErrors);
		end
	endtask

	initial begin
		seed = 32'h1d57235e;
		hold = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		cycles = 0;
		testErrors = 0;
		passCount = 0;
		failCount = 0;
		// Data memory has no reset and Verilator starts it at zero
		for (int i = 0; i < progWords; i++) begin
			dmem[i] = '0;
		end
		runTest(0, "alu ops");
		runTest(1, "ldi and flags");
		runTest(2, "store and load");
		runTest(3, "jumps");
		runTest(4, "random mix");
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
source/cpuPkg.sv
source/registerFile.sv
source/alu.sv
source/decoder.sv
source/processor.sv
source/processorTop.sv
verif/tbClock.sv
verif/processor_props.sv
verif/processorTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module processorTb

# Pass only if the pass message shows up in the output
./obj_dir/VprocessorTb | tee /dev/stderr | grep -q "^Simulation completed successfully$"
